// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int reg_addr_w = 3;
	localparam int instr_w = 16;

	// Register mirrored to the output port.
	localparam logic [reg_addr_w-1:0] out_reg = 3'd4;

	typedef enum logic [3:0] {
		op_add  = 4'h0,
		op_sub  = 4'h1,
		op_and  = 4'h2,
		op_or   = 4'h3,
		op_xor  = 4'h4,
		op_ldi  = 4'h5,
		op_addi = 4'h6,
		op_bnz  = 4'h7,
		op_halt = 4'h8
	} opcode_t;

	typedef struct packed {
		opcode_t                op;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [2:0]            pad;
	} instr_r_t;

	typedef struct packed {
		opcode_t                op;
		logic [reg_addr_w-1:0] rd;
		logic signed [8:0]     imm; // Two's complement.
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_t;

	typedef enum logic [2:0] {
		alu_add    = 3'd0,
		alu_sub    = 3'd1,
		alu_and    = 3'd2,
		alu_or     = 3'd3,
		alu_xor    = 3'd4,
		alu_pass_b = 3'd5
	} alu_op_t;

endpackage

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
	parameter int DATA_WIDTH = 32
) (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            wr_en,
	input  wire  [cpu_pkg::reg_addr_w-1:0] wr_a,
	input  wire  [DATA_WIDTH-1:0]          wr_d,
	input  wire                            rd_en,
	input  wire  [cpu_pkg::reg_addr_w-1:0] rd_a_a,
	input  wire  [cpu_pkg::reg_addr_w-1:0] rd_a_b,
	output logic [DATA_WIDTH-1:0]          rd_d_a,
	output logic [DATA_WIDTH-1:0]          rd_d_b,
	output logic [DATA_WIDTH-1:0]          reg4_out
);
	import cpu_pkg::*;

	localparam int num_regs = 2 ** reg_addr_w;

	logic [DATA_WIDTH-1:0] rf [num_regs];
	logic                  hit_a;
	logic                  hit_b;

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < num_regs; i++) begin
				rf[i] <= '0;
			end
		end else if (wr_en) begin
			rf[wr_a] <= wr_d;
		end
	end

	// Same-cycle write to a read address.
	assign hit_a = wr_en && (wr_a == rd_a_a);
	assign hit_b = wr_en && (wr_a == rd_a_b);

	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_d_a <= hit_a ? wr_d : rf[rd_a_a]; // New data wins.
			rd_d_b <= hit_b ? wr_d : rf[rd_a_b];
		end
	end

	assign reg4_out = rf[out_reg];

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu #(
	parameter int DATA_WIDTH = 32
) (
	input  wire  [DATA_WIDTH-1:0] a,
	input  wire  [DATA_WIDTH-1:0] b,
	input  wire  [8:0]            imm,
	input  wire                   b_sel,
	input  wire  cpu_pkg::alu_op_t op,
	output logic [DATA_WIDTH-1:0] result,
	output logic                  zero
);
	import cpu_pkg::*;

	logic [DATA_WIDTH-1:0] imm_ext;
	logic [DATA_WIDTH-1:0] b_imm;

	assign imm_ext = {{(DATA_WIDTH-9){imm[8]}}, imm}; // Sign extension.
	assign b_imm = b_sel ? imm_ext : b;

	always_comb begin
		case (op)
			alu_add:    result = a + b_imm;
			alu_sub:    result = a - b_imm;
			alu_and:    result = a & b_imm;
			alu_or:     result = a | b_imm;
			alu_xor:    result = a ^ b_imm;
			alu_pass_b: result = b_imm;
			default:    result = a + b_imm;
		endcase
	end

	// Branch test looks at operand a only.
	assign zero = (a == '0);

endmodule

`default_nettype wire

// File: design/prog_counter.sv
`timescale 1ns/1ps
`default_nettype none

module prog_counter #(
	parameter int PC_WIDTH = 6
) (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 clr,
	input  wire                 inc,
	input  wire                 load,
	input  wire  [PC_WIDTH-1:0] load_val,
	output logic [PC_WIDTH-1:0] pc
);

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc <= '0;
		end else if (clr) begin
			pc <= '0;
		end else if (load) begin
			pc <= load_val;
		end else if (inc) begin
			pc <= pc + 1'b1; // Wraps naturally.
		end
	end

endmodule

`default_nettype wire

// File: design/prog_mem.sv
`timescale 1ns/1ps
`default_nettype none

module prog_mem #(
	parameter int PC_WIDTH = 6
) (
	input  wire                  clk,
	input  wire                  wr_en,
	input  wire  [PC_WIDTH-1:0]  wr_addr,
	input  wire  cpu_pkg::instr_t wr_data,
	input  wire                  rd_en,
	input  wire  [PC_WIDTH-1:0]  rd_addr,
	output cpu_pkg::instr_t      rd_data
);
	import cpu_pkg::*;

	instr_t mem [2**PC_WIDTH];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		if (rd_en) begin
			rd_data <= mem[rd_addr]; // Holds until the next fetch.
		end
	end

endmodule

`default_nettype wire

// File: design/cpu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_ctrl (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            start,
	input  wire                            load_en,
	input  wire  cpu_pkg::instr_t          instr,
	input  wire                            zero,
	output logic                           busy,
	output logic                           halted,
	output logic                           pc_clr,
	output logic                           pc_inc,
	output logic                           pc_load,
	output logic                           mem_rd,
	output logic                           mem_wr,
	output logic                           rd_en,
	output logic [cpu_pkg::reg_addr_w-1:0] rd_a_a,
	output logic [cpu_pkg::reg_addr_w-1:0] rd_a_b,
	output logic                           wr_en,
	output logic [cpu_pkg::reg_addr_w-1:0] wr_a,
	output logic [8:0]                     imm,
	output logic                           b_sel,
	output cpu_pkg::alu_op_t               alu_op
);
	import cpu_pkg::*;

	localparam logic [1:0] st_idle  = 2'd0;
	localparam logic [1:0] st_fetch = 2'd1;
	localparam logic [1:0] st_read  = 2'd2;
	localparam logic [1:0] st_exec  = 2'd3;

	logic [1:0] state;
	logic [1:0] state_nxt;
	opcode_t    op;
	logic       is_imm;
	logic       writes_rd;
	logic       in_exec;

	assign op = instr.r.op;
	assign is_imm = (op == op_ldi) || (op == op_addi) || (op == op_bnz);
	assign in_exec = (state == st_exec);

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:  state_nxt = start ? st_fetch : st_idle;
			st_fetch: state_nxt = st_read;
			st_read:  state_nxt = st_exec;
			st_exec:  state_nxt = (op == op_halt) ? st_idle : st_fetch;
			default:  state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state  <= st_idle;
			halted <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == st_idle && start) begin
				halted <= 1'b0;
			end else if (in_exec && op == op_halt) begin
				halted <= 1'b1; // Same edge as busy falling.
			end
		end
	end

	always_comb begin
		writes_rd = 1'b1;
		case (op)
			op_add:  alu_op = alu_add;
			op_sub:  alu_op = alu_sub;
			op_and:  alu_op = alu_and;
			op_or:   alu_op = alu_or;
			op_xor:  alu_op = alu_xor;
			op_ldi:  alu_op = alu_pass_b;
			op_addi: alu_op = alu_add;
			default: begin
				alu_op    = alu_add;
				writes_rd = 1'b0; // bnz, halt and unused codes.
			end
		endcase
	end

	assign busy    = (state != st_idle);
	assign mem_wr  = load_en && (state == st_idle);
	assign pc_clr  = start && (state == st_idle);
	assign pc_inc  = (state == st_fetch);
	assign mem_rd  = (state == st_fetch);
	assign rd_en   = (state == st_read);
	assign rd_a_a  = is_imm ? instr.i.rd : instr.r.rs;
	assign rd_a_b  = instr.r.rt;
	assign wr_en   = in_exec && writes_rd;
	assign wr_a    = instr.i.rd;
	assign imm     = instr.i.imm;
	assign b_sel   = is_imm;
	assign pc_load = in_exec && (op == op_bnz) && !zero;

endmodule

`default_nettype wire

// File: design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
	parameter int DATA_WIDTH = 32,
	parameter int PC_WIDTH   = 6
) (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   start,
	input  wire                   load_en,
	input  wire  [PC_WIDTH-1:0]   load_addr,
	input  wire  cpu_pkg::instr_t load_data,
	output logic                  busy,
	output logic                  halted,
	output logic [DATA_WIDTH-1:0] port_out
);
	import cpu_pkg::*;

	logic                  pc_clr;
	logic                  pc_inc;
	logic                  pc_load;
	logic                  mem_rd;
	logic                  mem_wr;
	logic                  rd_en;
	logic                  wr_en;
	logic                  b_sel;
	logic                  zero;
	logic [reg_addr_w-1:0] rd_a_a;
	logic [reg_addr_w-1:0] rd_a_b;
	logic [reg_addr_w-1:0] wr_a;
	logic [8:0]            imm;
	logic [PC_WIDTH-1:0]   pc;
	logic [DATA_WIDTH-1:0] rd_d_a;
	logic [DATA_WIDTH-1:0] rd_d_b;
	logic [DATA_WIDTH-1:0] result;
	instr_t                instr;
	alu_op_t               alu_op;

	cpu_ctrl u_ctrl (
		.clk(clk), .rst(rst), .start(start), .load_en(load_en),
		.instr(instr), .zero(zero), .busy(busy), .halted(halted),
		.pc_clr(pc_clr), .pc_inc(pc_inc), .pc_load(pc_load),
		.mem_rd(mem_rd), .mem_wr(mem_wr), .rd_en(rd_en),
		.rd_a_a(rd_a_a), .rd_a_b(rd_a_b), .wr_en(wr_en), .wr_a(wr_a),
		.imm(imm), .b_sel(b_sel), .alu_op(alu_op)
	);

	// Branch target is the low bits of the immediate.
	prog_counter #(.PC_WIDTH(PC_WIDTH)) u_pc (
		.clk(clk), .rst(rst), .clr(pc_clr), .inc(pc_inc), .load(pc_load),
		.load_val(imm[PC_WIDTH-1:0]), .pc(pc)
	);

	prog_mem #(.PC_WIDTH(PC_WIDTH)) u_mem (
		.clk(clk), .wr_en(mem_wr), .wr_addr(load_addr), .wr_data(load_data),
		.rd_en(mem_rd), .rd_addr(pc), .rd_data(instr)
	);

	reg_file #(.DATA_WIDTH(DATA_WIDTH)) u_rf (
		.clk(clk), .rst(rst), .wr_en(wr_en), .wr_a(wr_a), .wr_d(result),
		.rd_en(rd_en), .rd_a_a(rd_a_a), .rd_a_b(rd_a_b),
		.rd_d_a(rd_d_a), .rd_d_b(rd_d_b), .reg4_out(port_out)
	);

	alu #(.DATA_WIDTH(DATA_WIDTH)) u_alu (
		.a(rd_d_a), .b(rd_d_b), .imm(imm), .b_sel(b_sel), .op(alu_op),
		.result(result), .zero(zero)
	);

endmodule

`default_nettype wire

// File: verification/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker #(
	parameter int DATA_WIDTH = 32
) (
	input wire                  clk,
	input wire                  rst,
	input wire                  start,
	input wire                  busy,
	input wire                  halted,
	input wire [DATA_WIDTH-1:0] port_out
);

	int fail_count = 0;

	assert property (@(posedge clk) disable iff (!rst) !(busy && halted))
		else begin
			$error("busy and halted are high together");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst) (start && !busy) |=> busy)
		else begin
			$error("start on an idle machine did not raise busy");
			fail_count++;
		end

	// Idle for two cycles means no write can be in flight.
	assert property (@(posedge clk) disable iff (!rst)
		(!busy && $past(!busy)) |-> $stable(port_out))
		else begin
			$error("port_out changed while the machine was idle");
			fail_count++;
		end

endmodule

bind cpu_top cpu_checker #(.DATA_WIDTH(DATA_WIDTH)) u_chk (
	.clk(clk), .rst(rst), .start(start), .busy(busy), .halted(halted),
	.port_out(port_out)
);

`default_nettype wire

// File: verification/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
	import cpu_pkg::*;

	localparam int data_w = 32;
	localparam int pc_w = 6;
	localparam int halt_limit = 500;

	logic              clk = 1'b0;
	logic              rst;
	logic              start;
	logic              load_en;
	logic [pc_w-1:0]   load_addr;
	instr_t            load_data;
	logic              busy;
	logic              halted;
	logic [data_w-1:0] port_out;

	instr_t            prog [$];
	logic [data_w-1:0] model_regs [8];
	int                errors = 0;
	int                passes = 0;
	int                seed = 20903;

	cpu_top #(.DATA_WIDTH(data_w), .PC_WIDTH(pc_w)) uut (
		.clk(clk), .rst(rst), .start(start), .load_en(load_en),
		.load_addr(load_addr), .load_data(load_data), .busy(busy),
		.halted(halted), .port_out(port_out)
	);

	always #20 clk = ~clk;

	task automatic check(input logic [data_w-1:0] exp, input logic [data_w-1:0] act,
			input string msg);
		if (act !== exp) begin
			$display("ERR @%0t ns: %s expected %h got %h", $time, msg, exp, act);
			errors++;
		end else begin
			passes++;
		end
	endtask

	task automatic report(input string name, input int err_before);
		if (errors == err_before)
			$display("test %s: ok", name);
		else
			$display("test %s: FAILED", name);
	endtask

	function automatic instr_t enc_r(input opcode_t op, input int rd, input int rs,
			input int rt);
		instr_t w;
		w.r.op = op;
		w.r.rd = rd[2:0];
		w.r.rs = rs[2:0];
		w.r.rt = rt[2:0];
		w.r.pad = 3'b000;
		return w;
	endfunction

	function automatic instr_t enc_i(input opcode_t op, input int rd, input int imm);
		instr_t w;
		w.i.op = op;
		w.i.rd = rd[2:0];
		w.i.imm = imm[8:0];
		return w;
	endfunction

	function automatic logic [data_w-1:0] sext(input logic [8:0] v);
		return {{(data_w-9){v[8]}}, v};
	endfunction

	// Instruction-level model; registers persist between programs like the DUT.
	task automatic model_run;
		int     pc;
		bit     done;
		instr_t ins;
		pc = 0;
		done = 1'b0;
		for (int step = 0; step < 1000 && !done && pc < prog.size(); step++) begin
			ins = prog[pc];
			pc++;
			case (ins.r.op)
				op_add:  model_regs[ins.r.rd] = model_regs[ins.r.rs] + model_regs[ins.r.rt];
				op_sub:  model_regs[ins.r.rd] = model_regs[ins.r.rs] - model_regs[ins.r.rt];
				op_and:  model_regs[ins.r.rd] = model_regs[ins.r.rs] & model_regs[ins.r.rt];
				op_or:   model_regs[ins.r.rd] = model_regs[ins.r.rs] | model_regs[ins.r.rt];
				op_xor:  model_regs[ins.r.rd] = model_regs[ins.r.rs] ^ model_regs[ins.r.rt];
				op_ldi:  model_regs[ins.i.rd] = sext(ins.i.imm);
				op_addi: model_regs[ins.i.rd] = model_regs[ins.i.rd] + sext(ins.i.imm);
				op_bnz:  if (model_regs[ins.i.rd] != '0) pc = int'(ins.i.imm[pc_w-1:0]);
				op_halt: done = 1'b1;
				default: ;
			endcase
		end
	endtask

	task automatic load_prog;
		for (int a = 0; a < prog.size(); a++) begin
			@(posedge clk);
			load_en <= 1'b1;
			load_addr <= a[pc_w-1:0];
			load_data <= prog[a];
		end
		@(posedge clk);
		load_en <= 1'b0;
	endtask

	task automatic start_pulse;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_halt;
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!halted && n < halt_limit);
		if (!halted) begin
			$display("Timeout: the machine did not halt within %0d cycles", halt_limit);
			errors++;
		end
	endtask

	task automatic run_and_check(input string msg);
		load_prog();
		model_run();
		start_pulse();
		wait_halt();
		check(model_regs[4], port_out, msg);
		check('0, {31'd0, busy}, {msg, " busy after halt"});
	endtask

	task automatic test_reset;
		int e;
		e = errors;
		@(negedge clk);
		check('0, {31'd0, busy}, "busy after reset");
		check('0, {31'd0, halted}, "halted after reset");
		check('0, port_out, "port_out after reset");
		report("reset", e);
	endtask

	task automatic test_arith;
		int e;
		e = errors;
		prog = '{enc_i(op_ldi, 1, 100), enc_i(op_ldi, 2, -37), enc_i(op_addi, 1, -5),
			enc_r(op_sub, 5, 1, 2), enc_i(op_ldi, 3, -1), enc_r(op_add, 4, 5, 3),
			enc_i(op_halt, 0, 0)};
		run_and_check("arith r4"); // Last add wraps past 2**32.
		report("arith", e);
	endtask

	task automatic test_logic;
		int          e;
		logic [8:0]  va;
		logic [8:0]  vb;
		opcode_t     ops [3];
		e = errors;
		ops = '{op_and, op_or, op_xor};
		for (int k = 0; k < 3; k++) begin
			va = $random(seed);
			vb = $random(seed);
			prog = '{enc_i(op_ldi, 1, int'(va)), enc_i(op_ldi, 2, int'(vb)),
				enc_r(ops[k], 4, 1, 2), enc_i(op_halt, 0, 0)};
			run_and_check($sformatf("logic op %s", ops[k].name()));
		end
		report("logic", e);
	endtask

	task automatic test_dep;
		int e;
		e = errors;
		prog = '{enc_i(op_ldi, 1, 7), enc_i(op_addi, 1, 3), enc_r(op_add, 2, 1, 1),
			enc_r(op_sub, 3, 2, 1), enc_r(op_xor, 4, 3, 2), enc_i(op_addi, 4, 1),
			enc_i(op_halt, 0, 0)};
		run_and_check("dependency r4");
		report("dependency", e);
	endtask

	task automatic test_loop;
		int e;
		e = errors;
		prog = '{enc_i(op_ldi, 1, 5), enc_i(op_ldi, 2, 13), enc_i(op_ldi, 4, 0),
			enc_r(op_add, 4, 4, 2), enc_i(op_addi, 1, -1), enc_i(op_bnz, 1, 3),
			enc_i(op_halt, 0, 0)};
		run_and_check("loop r4");
		check(32'd65, port_out, "loop r4 against count times step");
		report("loop", e);
	endtask

	task automatic test_reload;
		int e;
		e = errors;
		prog = '{enc_i(op_ldi, 4, 11), enc_i(op_addi, 4, 4), enc_i(op_addi, 4, 4),
			enc_i(op_addi, 4, 4), enc_i(op_addi, 4, 4), enc_i(op_halt, 0, 0)};
		load_prog();
		model_run();
		start_pulse();
		for (int a = 2; a < 6; a++) begin
			@(posedge clk);
			load_en <= 1'b1; // Must be ignored while running.
			load_addr <= a[pc_w-1:0];
			load_data <= enc_i(op_halt, 0, 0);
		end
		@(posedge clk);
		load_en <= 1'b0;
		wait_halt();
		check(model_regs[4], port_out, "first program r4");
		prog = '{enc_i(op_ldi, 4, -20), enc_i(op_addi, 4, 5), enc_i(op_halt, 0, 0)};
		load_prog();
		model_run();
		start_pulse();
		@(negedge clk);
		check('0, {31'd0, halted}, "halted after restart");
		wait_halt();
		check(model_regs[4], port_out, "second program r4");
		report("reload", e);
	endtask

	initial begin
		rst = 1'b0;
		start = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		for (int i = 0; i < 8; i++) begin
			model_regs[i] = '0;
		end
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		test_reset();
		test_arith();
		test_logic();
		test_dep();
		test_loop();
		test_reload();
		errors += uut.u_chk.fail_count; // Assertion failures from the bound checker.
		$display("Checks passed: %0d, errors: %0d", passes, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
design/cpu_pkg.sv
design/reg_file.sv
design/alu.sv
design/prog_counter.sv
design/prog_mem.sv
design/cpu_ctrl.sv
design/cpu_top.sv
verification/cpu_checker.sv
verification/cpu_tb.sv

// File: Bender.yml
package:
  name: small_cpu

sources:
  - files:
      - design/cpu_pkg.sv
      - design/reg_file.sv
      - design/alu.sv
      - design/prog_counter.sv
      - design/prog_mem.sv
      - design/cpu_ctrl.sv
      - design/cpu_top.sv
  - target: test
    files:
      - verification/cpu_checker.sv
      - verification/cpu_tb.sv
